// File: hdl/sqPkg.sv
package sqPkg;

    // Queue geometry
    localparam int SQ_ENTRIES = 8;
    localparam int IDX_W = 3;
    localparam int SQN_W = IDX_W + 1;
    localparam int TAG_W = 6;

    // Load size codes
    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;

    typedef logic [IDX_W-1:0] sqIdxT;
    typedef logic [SQN_W-1:0] sqnT;
    typedef logic [TAG_W-1:0] tagT;

    // Store data word, holds the producer tag until the result is captured
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [31-TAG_W:0] fill;
            tagT tag;
        } pend;
    } sqDataU;

    typedef struct packed {
        sqDataU data;
        logic [29:0] addr;
        logic [3:0] wmask;
        sqnT sqN;
        logic addrAvail;
        logic dataAvail;
    } sqEntryT;

    typedef struct packed {
        logic valid;
        tagT tag;
    } enqReqT;

    typedef struct packed {
        logic valid;
        sqnT sqN;
        logic [29:0] addr;
        logic [3:0] wmask;
    } addrReqT;

    typedef struct packed {
        logic valid;
        tagT tag;
        logic [31:0] data;
    } resultBusT;

    // sqN is the number of the next store younger than the load
    typedef struct packed {
        logic valid;
        logic [31:0] addr;
        logic [1:0] size;
        sqnT sqN;
    } loadReqT;

    typedef struct packed {
        logic valid;
        logic [31:0] data;
        logic [3:0] mask;
        logic conflict;
    } fwdResultT;

    typedef struct packed {
        logic valid;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0] wmask;
    } storeUopT;

    // Move the low byte or half into the lanes of the write mask
    function automatic logic [31:0] placeBytes(logic [31:0] raw, logic [3:0] wmask);
        logic [31:0] placed;
        placed = '0;
        case (wmask)
            4'b0001: placed[7:0] = raw[7:0];
            4'b0010: placed[15:8] = raw[7:0];
            4'b0100: placed[23:16] = raw[7:0];
            4'b1000: placed[31:24] = raw[7:0];
            4'b0011: placed[15:0] = raw[15:0];
            4'b1100: placed[31:16] = raw[15:0];
            default: placed = raw;
        endcase
        return placed;
    endfunction

    function automatic logic [3:0] readMaskOf(logic [1:0] size, logic [1:0] lowAddr);
        case (size)
            SIZE_BYTE: return 4'b0001 << lowAddr;
            SIZE_HALF: return lowAddr[1] ? 4'b1100 : 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    // True when a was allocated before b, with wrap
    function automatic logic isOlder(sqnT a, sqnT b);
        sqnT diff;
        diff = a - b;
        return diff[SQN_W-1];
    endfunction

endpackage

// File: hdl/sqEntryArray.sv
`timescale 1ns/1ps

module sqEntryArray (
    input  logic clk,
    input  logic rst,
    input  sqPkg::enqReqT enq,
    input  sqPkg::addrReqT addrIn,
    input  sqPkg::resultBusT resultIn,
    input  logic deq,
    output sqPkg::sqEntryT [sqPkg::SQ_ENTRIES-1:0] entries,
    output logic [sqPkg::SQ_ENTRIES-1:0] entryValid,
    output sqPkg::sqnT headSqN,
    output sqPkg::sqnT enqSqN,
    output logic full,
    output logic empty
);

    sqPkg::sqnT tailSqN;
    sqPkg::sqnT count;
    sqPkg::sqIdxT tailIdx;
    sqPkg::sqIdxT addrIdx;

    assign tailIdx = tailSqN[sqPkg::IDX_W-1:0];
    assign addrIdx = addrIn.sqN[sqPkg::IDX_W-1:0];

    // One extra sequence bit tells full from empty
    assign count = tailSqN - headSqN;
    assign enqSqN = tailSqN;
    assign full = (count == sqPkg::sqnT'(sqPkg::SQ_ENTRIES));
    assign empty = (count == '0);

    // An entry is live when its distance from the head is below the count
    always_comb begin
        sqPkg::sqIdxT offset;
        for (int i = 0; i < sqPkg::SQ_ENTRIES; i++) begin
            offset = sqPkg::sqIdxT'(i) - headSqN[sqPkg::IDX_W-1:0];
            entryValid[i] = ({1'b0, offset} < count);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            headSqN <= '0;
            tailSqN <= '0;
        end else begin
            if (enq.valid) begin
                tailSqN <= tailSqN + 1'b1;
            end
            if (deq) begin
                headSqN <= headSqN + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < sqPkg::SQ_ENTRIES; i++) begin
                entries[i].addrAvail <= 1'b0;
                entries[i].dataAvail <= 1'b0;
            end
        end else begin
            // Result bus snoop replaces the tag in the union with the data
            for (int i = 0; i < sqPkg::SQ_ENTRIES; i++) begin
                if (resultIn.valid && entryValid[i] && !entries[i].dataAvail &&
                    entries[i].data.pend.tag == resultIn.tag) begin
                    entries[i].data.raw <= resultIn.data;
                    entries[i].dataAvail <= 1'b1;
                end
            end

            if (addrIn.valid) begin
                entries[addrIdx].addr <= addrIn.addr;
                entries[addrIdx].wmask <= addrIn.wmask;
                entries[addrIdx].addrAvail <= 1'b1;
            end

            // New store waits for both its address and its data
            if (enq.valid) begin
                entries[tailIdx].data.pend.fill <= '0;
                entries[tailIdx].data.pend.tag <= enq.tag;
                entries[tailIdx].sqN <= tailSqN;
                entries[tailIdx].addrAvail <= 1'b0;
                entries[tailIdx].dataAvail <= 1'b0;
            end
        end
    end

    // The rename stage must hold stores back when no slot is free
    assert property (@(posedge clk) disable iff (rst) enq.valid |-> !full)
        else $error("store enqueued while queue full");

    // AGU writes each live store's address exactly once
    assert property (@(posedge clk) disable iff (rst)
        addrIn.valid |-> entryValid[addrIdx] && !entries[addrIdx].addrAvail)
        else $error("address write to dead or already addressed entry");

endmodule

// File: hdl/sqForward.sv
`timescale 1ns/1ps

module sqForward (
    input  logic clk,
    input  logic rst,
    input  sqPkg::loadReqT loadIn,
    input  sqPkg::sqEntryT [sqPkg::SQ_ENTRIES-1:0] entries,
    input  logic [sqPkg::SQ_ENTRIES-1:0] entryValid,
    input  sqPkg::sqnT headSqN,
    output sqPkg::fwdResultT fwdOut
);

    logic [3:0] readMask;
    logic [31:0] fwdData;
    logic [3:0] covered;
    logic conflict;

    assign readMask = sqPkg::readMaskOf(loadIn.size, loadIn.addr[1:0]);

    // Walk from the head so younger hits overwrite older bytes
    always_comb begin
        sqPkg::sqIdxT idx;
        sqPkg::sqEntryT cand;
        logic [31:0] placed;
        logic hit;
        fwdData = '0;
        covered = '0;
        conflict = 1'b0;
        for (int k = 0; k < sqPkg::SQ_ENTRIES; k++) begin
            idx = headSqN[sqPkg::IDX_W-1:0] + sqPkg::sqIdxT'(k);
            cand = entries[idx];
            placed = sqPkg::placeBytes(cand.data.raw, cand.wmask);
            hit = entryValid[idx] && cand.addrAvail &&
                  (cand.addr == loadIn.addr[31:2]) &&
                  sqPkg::isOlder(cand.sqN, loadIn.sqN);
            if (hit) begin
                if (cand.dataAvail) begin
                    for (int j = 0; j < 4; j++) begin
                        if (cand.wmask[j] && readMask[j]) begin
                            fwdData[j*8 +: 8] = placed[j*8 +: 8];
                            covered[j] = 1'b1;
                        end
                    end
                end else if ((cand.wmask & readMask) != '0) begin
                    // Overlapping store still waits for its data
                    conflict = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fwdOut.valid <= 1'b0;
        end else begin
            fwdOut.valid <= loadIn.valid;
        end
        if (loadIn.valid) begin
            fwdOut.data <= fwdData;
            // Bytes the load does not read count as available
            fwdOut.mask <= ~readMask | covered;
            fwdOut.conflict <= conflict;
        end
    end

    // One result per load, exactly one cycle later
    assert property (@(posedge clk) disable iff (rst)
        loadIn.valid |=> fwdOut.valid)
        else $error("forward result missing one cycle after load");

    assert property (@(posedge clk) disable iff (rst)
        !loadIn.valid |=> !fwdOut.valid)
        else $error("forward result without a load");

endmodule

// File: hdl/sqDrain.sv
`timescale 1ns/1ps

module sqDrain (
    input  logic clk,
    input  logic rst,
    input  logic stall,
    input  sqPkg::sqnT comSqN,
    input  sqPkg::sqEntryT [sqPkg::SQ_ENTRIES-1:0] entries,
    input  logic [sqPkg::SQ_ENTRIES-1:0] entryValid,
    input  sqPkg::sqnT headSqN,
    output sqPkg::storeUopT storeOut,
    output logic deq
);

    sqPkg::sqIdxT headIdx;
    sqPkg::sqEntryT headEntry;
    logic headReady;

    assign headIdx = headSqN[sqPkg::IDX_W-1:0];
    assign headEntry = entries[headIdx];

    // Committed, addressed and with data
    assign headReady = entryValid[headIdx] &&
                       headEntry.addrAvail &&
                       headEntry.dataAvail &&
                       sqPkg::isOlder(headSqN, comSqN);

    assign deq = headReady && !stall;

    always_ff @(posedge clk) begin
        if (rst) begin
            storeOut <= '0;
        end else if (!stall) begin
            if (headReady) begin
                storeOut.valid <= 1'b1;
                storeOut.addr <= {headEntry.addr, 2'b00};
                storeOut.data <= sqPkg::placeBytes(headEntry.data.raw, headEntry.wmask);
                storeOut.wmask <= headEntry.wmask;
            end else begin
                storeOut.valid <= 1'b0;
            end
        end
    end

    // Downstream sees a frozen store while it stalls
    assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable(storeOut))
        else $error("store output changed under stall");

endmodule

// File: hdl/storeQueue.sv
`timescale 1ns/1ps

module storeQueue (
    input  logic clk,
    input  logic rst,
    input  sqPkg::enqReqT enq,
    input  sqPkg::addrReqT addrIn,
    input  sqPkg::resultBusT resultIn,
    input  sqPkg::loadReqT loadIn,
    input  sqPkg::sqnT comSqN,
    input  logic stall,
    output sqPkg::sqnT enqSqN,
    output logic full,
    output logic empty,
    output sqPkg::fwdResultT fwdOut,
    output sqPkg::storeUopT storeOut
);

    // Entry state shared by the forwarding and drain sides
    sqPkg::sqEntryT [sqPkg::SQ_ENTRIES-1:0] entries;
    logic [sqPkg::SQ_ENTRIES-1:0] entryValid;
    sqPkg::sqnT headSqN;
    logic deq;

    sqEntryArray uArray (
        .clk        (clk),
        .rst        (rst),
        .enq        (enq),
        .addrIn     (addrIn),
        .resultIn   (resultIn),
        .deq        (deq),
        .entries    (entries),
        .entryValid (entryValid),
        .headSqN    (headSqN),
        .enqSqN     (enqSqN),
        .full       (full),
        .empty      (empty)
    );

    sqForward uForward (
        .clk        (clk),
        .rst        (rst),
        .loadIn     (loadIn),
        .entries    (entries),
        .entryValid (entryValid),
        .headSqN    (headSqN),
        .fwdOut     (fwdOut)
    );

    // Dequeue pulse goes back to the array head pointer
    sqDrain uDrain (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .comSqN     (comSqN),
        .entries    (entries),
        .entryValid (entryValid),
        .headSqN    (headSqN),
        .storeOut   (storeOut),
        .deq        (deq)
    );

endmodule

// File: tests/sqModel.svh
`ifndef SQ_MODEL_SVH
`define SQ_MODEL_SVH

// One queued store as the testbench sees it, kept in program order
typedef struct packed {
    sqPkg::sqnT sqN;
    sqPkg::tagT tag;
    logic [31:0] data;
    logic [29:0] addr;
    logic [3:0] wmask;
    logic addrAvail;
    logic dataAvail;
} modelEntryT;

modelEntryT mq[$];
sqPkg::sqnT mTail;
sqPkg::storeUopT expStore;
logic expFwdValid;
logic [31:0] expFwdData;
logic [3:0] expFwdMask;
logic [3:0] expFwdCovered;
logic expFwdConflict;

// a comes first when b lies one to eight numbers ahead of it
function automatic logic precedes(sqPkg::sqnT a, sqPkg::sqnT b);
    sqPkg::sqnT gap;
    gap = b - a;
    return (gap != 0) && (gap <= 8);
endfunction

function automatic logic [3:0] readBytes(logic [1:0] size, logic [1:0] low);
    logic [3:0] m;
    for (int b = 0; b < 4; b++) begin
        if (size == 2'd0) begin
            m[b] = (b == low);
        end else if (size == 2'd1) begin
            m[b] = ((b / 2) == low[1]);
        end else begin
            m[b] = 1'b1;
        end
    end
    return m;
endfunction

// Narrow stores repeat their low byte or half across the word, then keep their lanes
function automatic logic [31:0] laneData(logic [31:0] raw, logic [3:0] wmask);
    logic [31:0] lanes;
    lanes = {{8{wmask[3]}}, {8{wmask[2]}}, {8{wmask[1]}}, {8{wmask[0]}}};
    if ($countones(wmask) == 1) begin
        return {4{raw[7:0]}} & lanes;
    end else if (wmask == 4'b0011 || wmask == 4'b1100) begin
        return {2{raw[15:0]}} & lanes;
    end
    return raw;
endfunction

task automatic modelReset();
    mq.delete();
    mTail = '0;
    expStore = '0;
    expFwdValid = 1'b0;
endtask

// Applies what the DUT consumed at this clock edge
task automatic modelStep(sqPkg::enqReqT enqReq, sqPkg::addrReqT addrReq,
                         sqPkg::resultBusT result, sqPkg::loadReqT load,
                         sqPkg::sqnT com, logic stallNow);
    logic [3:0] rd;
    logic [31:0] word;
    logic drain;
    modelEntryT fresh;
    expFwdValid = load.valid;
    if (load.valid) begin
        rd = readBytes(load.size, load.addr[1:0]);
        expFwdData = '0;
        expFwdCovered = '0;
        expFwdConflict = 1'b0;
        // Oldest first, so the youngest older store has the last word
        foreach (mq[i]) begin
            if (mq[i].addrAvail && mq[i].addr == load.addr[31:2] &&
                precedes(mq[i].sqN, load.sqN)) begin
                if (mq[i].dataAvail) begin
                    word = laneData(mq[i].data, mq[i].wmask);
                    for (int b = 0; b < 4; b++) begin
                        if (mq[i].wmask[b] && rd[b]) begin
                            expFwdData[b*8 +: 8] = word[b*8 +: 8];
                            expFwdCovered[b] = 1'b1;
                        end
                    end
                end else if ((mq[i].wmask & rd) != 4'b0000) begin
                    expFwdConflict = 1'b1;
                end
            end
        end
        expFwdMask = ~rd | expFwdCovered;
    end
    drain = !stallNow && (mq.size() > 0) && mq[0].addrAvail && mq[0].dataAvail &&
            precedes(mq[0].sqN, com);
    if (!stallNow) begin
        expStore.valid = drain;
        if (drain) begin
            expStore.addr = {mq[0].addr, 2'b00};
            expStore.data = laneData(mq[0].data, mq[0].wmask);
            expStore.wmask = mq[0].wmask;
        end
    end
    if (result.valid) begin
        foreach (mq[i]) begin
            if (!mq[i].dataAvail && mq[i].tag == result.tag) begin
                mq[i].data = result.data;
                mq[i].dataAvail = 1'b1;
            end
        end
    end
    if (addrReq.valid) begin
        foreach (mq[i]) begin
            if (mq[i].sqN == addrReq.sqN) begin
                mq[i].addr = addrReq.addr;
                mq[i].wmask = addrReq.wmask;
                mq[i].addrAvail = 1'b1;
            end
        end
    end
    if (drain) begin
        mq.delete(0);
    end
    if (enqReq.valid) begin
        fresh = '0;
        fresh.sqN = mTail;
        fresh.tag = enqReq.tag;
        mq.push_back(fresh);
        mTail = mTail + 1'b1;
    end
endtask

`endif

// File: tests/storeQueueTb.sv
`timescale 1ns/1ps

module storeQueueTb;

    localparam int RANDOM_CYCLES = 1500;
    localparam int TIMEOUT_CYCLES = 2000;

    logic clk;
    logic rst;
    sqPkg::enqReqT enq;
    sqPkg::addrReqT addrIn;
    sqPkg::resultBusT resultIn;
    sqPkg::loadReqT loadIn;
    sqPkg::sqnT comSqN;
    logic stall;
    sqPkg::sqnT enqSqN;
    logic full;
    logic empty;
    sqPkg::fwdResultT fwdOut;
    sqPkg::storeUopT storeOut;

    int cycleCount;
    sqPkg::tagT nextTag;
    sqPkg::sqnT comPtr;

    `include "sqModel.svh"

    storeQueue u_dut (
        .clk      (clk),
        .rst      (rst),
        .enq      (enq),
        .addrIn   (addrIn),
        .resultIn (resultIn),
        .loadIn   (loadIn),
        .comSqN   (comSqN),
        .stall    (stall),
        .enqSqN   (enqSqN),
        .full     (full),
        .empty    (empty),
        .fwdOut   (fwdOut),
        .storeOut (storeOut)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic stopWithError(string line);
        $display("%s", line);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on first error");
    endtask

    function automatic string mismatchLine(string what);
        return $sformatf("Mismatch at %0t: %s", $time, what);
    endfunction

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            stopWithError("Timeout: the queue did not drain within the cycle limit");
        end
    end

    function automatic int randBelow(int n);
        return int'($urandom % n);
    endfunction

    // Two neighbouring words catch a sloppy word compare
    function automatic logic [29:0] poolWord(int k);
        case (k)
            0: return 30'h0000_0040;
            1: return 30'h0000_0041;
            2: return 30'h0123_4560;
            default: return 30'h3fff_fffc;
        endcase
    endfunction

    function automatic logic [3:0] legalMask(int k);
        case (k)
            0: return 4'b0001;
            1: return 4'b0010;
            2: return 4'b0100;
            3: return 4'b1000;
            4: return 4'b0011;
            5: return 4'b1100;
            default: return 4'b1111;
        endcase
    endfunction

    task automatic checkOutputs();
        assert (enqSqN == mTail)
            else stopWithError(mismatchLine($sformatf("enqSqN %0d, expected %0d", enqSqN, mTail)));
        assert (full == (mq.size() == sqPkg::SQ_ENTRIES))
            else stopWithError(mismatchLine($sformatf("full %b with %0d held", full, mq.size())));
        assert (empty == (mq.size() == 0))
            else stopWithError(mismatchLine($sformatf("empty %b with %0d held", empty, mq.size())));
        assert (fwdOut.valid == expFwdValid)
            else stopWithError(mismatchLine($sformatf("fwdOut.valid %b", fwdOut.valid)));
        if (expFwdValid) begin
            assert (fwdOut.mask == expFwdMask)
                else stopWithError(mismatchLine($sformatf("fwd mask %b, expected %b",
                                                          fwdOut.mask, expFwdMask)));
            assert (fwdOut.conflict == expFwdConflict)
                else stopWithError(mismatchLine($sformatf("fwd conflict %b, expected %b",
                                                          fwdOut.conflict, expFwdConflict)));
            for (int b = 0; b < 4; b++) begin
                if (expFwdCovered[b]) begin
                    assert (fwdOut.data[b*8 +: 8] == expFwdData[b*8 +: 8])
                        else stopWithError(mismatchLine($sformatf("fwd data %h, expected %h",
                                                                  fwdOut.data, expFwdData)));
                end
            end
        end
        assert (storeOut.valid == expStore.valid)
            else stopWithError(mismatchLine($sformatf("storeOut.valid %b", storeOut.valid)));
        if (expStore.valid) begin
            assert (storeOut.addr == expStore.addr && storeOut.wmask == expStore.wmask)
                else stopWithError(mismatchLine($sformatf("store addr %h mask %b, expected %h %b",
                    storeOut.addr, storeOut.wmask, expStore.addr, expStore.wmask)));
            assert (storeOut.data == expStore.data)
                else stopWithError(mismatchLine($sformatf("store data %h, expected %h",
                                                          storeOut.data, expStore.data)));
        end
    endtask

    // The final phase commits everything and completes every pending store
    task automatic driveInputs(logic finalPhase);
        int pick;
        int noAddr[$];
        int noData[$];
        logic [1:0] low;
        enq = '0;
        addrIn = '0;
        resultIn = '0;
        loadIn = '0;
        foreach (mq[i]) begin
            if (!mq[i].addrAvail) noAddr.push_back(i);
            if (!mq[i].dataAvail) noData.push_back(i);
        end
        if (!finalPhase && mq.size() < sqPkg::SQ_ENTRIES && randBelow(100) < 45) begin
            enq.valid = 1'b1;
            enq.tag = nextTag;
            nextTag = nextTag + 1'b1;
        end
        if (noAddr.size() > 0 && (finalPhase || randBelow(100) < 60)) begin
            pick = noAddr[randBelow(noAddr.size())];
            addrIn.valid = 1'b1;
            addrIn.sqN = mq[pick].sqN;
            addrIn.addr = poolWord(randBelow(4));
            addrIn.wmask = legalMask(randBelow(7));
        end
        if (noData.size() > 0 && (finalPhase || randBelow(100) < 50)) begin
            pick = noData[randBelow(noData.size())];
            resultIn.valid = 1'b1;
            resultIn.tag = mq[pick].tag;
            resultIn.data = $urandom;
        end
        if (!finalPhase && randBelow(100) < 60) begin
            loadIn.valid = 1'b1;
            loadIn.size = 2'(randBelow(3));
            low = 2'(randBelow(4));
            if (loadIn.size == 2'd1) low[0] = 1'b0;
            if (loadIn.size == 2'd2) low = 2'b00;
            loadIn.addr = {poolWord(randBelow(4)), low};
            loadIn.sqN = mTail - sqPkg::sqnT'(randBelow(mq.size() + 1));
        end
        if (finalPhase) begin
            comPtr = mTail;
        end else if (comPtr != mTail && randBelow(100) < 40) begin
            comPtr = comPtr + 1'b1;
        end
        comSqN = comPtr;
        stall = !finalPhase && (randBelow(100) < 20);
    endtask

    task automatic runCycle(logic finalPhase);
        @(posedge clk);
        modelStep(enq, addrIn, resultIn, loadIn, comSqN, stall);
        #1;
        checkOutputs();
        #1;
        driveInputs(finalPhase);
    endtask

    initial begin
        void'($urandom(32'h9b6a_9010));
        cycleCount = 0;
        nextTag = '0;
        comPtr = '0;
        rst = 1'b1;
        enq = '0;
        addrIn = '0;
        resultIn = '0;
        loadIn = '0;
        comSqN = '0;
        stall = 1'b0;
        modelReset();
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            runCycle(1'b0);
        end
        while (mq.size() != 0) begin
            runCycle(1'b1);
        end
        // Let the last drained store show up and clear
        repeat (3) runCycle(1'b1);
        if (empty && !storeOut.valid && mq.size() == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("The queue was not empty after the drain phase");
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+tests
hdl/sqPkg.sv
hdl/sqEntryArray.sv
hdl/sqForward.sv
hdl/sqDrain.sv
hdl/storeQueue.sv
tests/storeQueueTb.sv
